//--- design/soc_event_pkg.sv
`default_nettype none

package soc_event_pkg;

    ////////////////////////////////////////
    // Event widths
    ////////////////////////////////////////

    localparam int UDMA_EVENTS      = 128;
    localparam int PER_EVNT_NUM     = 160;
    localparam int EVNT_WIDTH       = 8;
    localparam int FC_EVENTS_WIDTH  = 32;

    // Lines per small event group
    localparam int ADV_TIMER_EVENTS = 4;
    localparam int HWPE_EVENTS      = 2;
    localparam int HP_EVENTS        = 2;

    ////////////////////////////////////////
    // Peripheral event numbers
    ////////////////////////////////////////

    localparam int EVT_ADV_TIMER_BASE = 135;
    localparam int EVT_GPIO           = 139;
    localparam int EVT_HWPE_BASE      = 140;

    ////////////////////////////////////////
    // Fabric controller bit positions
    ////////////////////////////////////////

    // Bits 7:0 are kept for software events
    localparam int FC_BIT_DMA_EVT        = 8;
    localparam int FC_BIT_DMA_IRQ        = 9;
    localparam int FC_BIT_TIMER_LO       = 10;
    localparam int FC_BIT_TIMER_HI       = 11;
    localparam int FC_BIT_PF             = 12;
    localparam int FC_BIT_REF_EDGE       = 14;
    localparam int FC_BIT_GPIO           = 15;
    localparam int FC_BIT_ADV_TIMER_BASE = 17;
    localparam int FC_BIT_ERR            = 29;
    localparam int FC_BIT_HP_BASE        = 30;

    typedef logic [PER_EVNT_NUM-1:0]    per_evt_vec_t;
    typedef logic [EVNT_WIDTH-1:0]      evt_id_t;
    typedef logic [FC_EVENTS_WIDTH-1:0] fc_evt_vec_t;

    // Encoder holds one id until the fabric controller takes it
    typedef enum logic {
        ENC_IDLE,
        ENC_HOLD
    } encode_state_t;

endpackage

`default_nettype wire

//--- design/evt_bundle_if.sv
`timescale 1ns/1ps
`default_nettype none

// Sampled event pulses, one cycle wide, from sync to collect
interface evt_bundle_if import soc_event_pkg::*; ();

    logic [UDMA_EVENTS-1:0]      udma_evt;
    logic [ADV_TIMER_EVENTS-1:0] adv_timer_evt;
    logic                        gpio_evt;
    logic [HWPE_EVENTS-1:0]      hwpe_evt;
    logic                        dma_pe_evt;
    logic                        dma_pe_irq;
    logic                        pf_evt;
    logic                        timer_lo_evt;
    logic                        timer_hi_evt;
    logic                        err_evt;
    logic [HP_EVENTS-1:0]        hp_evt;
    // Either edge of the slow reference clock
    logic                        ref_edge;

    modport src (
        output udma_evt, adv_timer_evt, gpio_evt, hwpe_evt,
        output dma_pe_evt, dma_pe_irq, pf_evt,
        output timer_lo_evt, timer_hi_evt, err_evt, hp_evt,
        output ref_edge
    );

    modport dst (
        input udma_evt, adv_timer_evt, gpio_evt, hwpe_evt,
        input dma_pe_evt, dma_pe_irq, pf_evt,
        input timer_lo_evt, timer_hi_evt, err_evt, hp_evt,
        input ref_edge
    );

endinterface

`default_nettype wire

//--- design/event_sync_stage.sv
`timescale 1ns/1ps
`default_nettype none

module event_sync_stage import soc_event_pkg::*; (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        slow_clk_i,
    input  logic [UDMA_EVENTS-1:0]      udma_events_i,
    input  logic [ADV_TIMER_EVENTS-1:0] adv_timer_events_i,
    input  logic                        gpio_event_i,
    input  logic [HWPE_EVENTS-1:0]      fc_hwpe_events_i,
    input  logic                        dma_pe_evt_i,
    input  logic                        dma_pe_irq_i,
    input  logic                        pf_evt_i,
    input  logic                        timer_lo_event_i,
    input  logic                        timer_hi_event_i,
    input  logic                        err_event_i,
    input  logic [HP_EVENTS-1:0]        fc_hp_events_i,
    evt_bundle_if.src                   evt
);

    logic [UDMA_EVENTS-1:0]      udma_q;
    logic [ADV_TIMER_EVENTS-1:0] adv_timer_q;
    logic                        gpio_q;
    logic [HWPE_EVENTS-1:0]      hwpe_q;
    logic                        dma_pe_evt_q;
    logic                        dma_pe_irq_q;
    logic                        pf_q;
    logic                        timer_lo_q;
    logic                        timer_hi_q;
    logic                        err_q;
    logic [HP_EVENTS-1:0]        hp_q;

    // Slow clock synchronizer and edge register
    logic slow_meta_q;
    logic slow_sync_q;
    logic slow_prev_q;

    ////////////////////////////////////////
    // Input sampling
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            udma_q       <= '0;
            adv_timer_q  <= '0;
            gpio_q       <= 1'b0;
            hwpe_q       <= '0;
            dma_pe_evt_q <= 1'b0;
            dma_pe_irq_q <= 1'b0;
            pf_q         <= 1'b0;
            timer_lo_q   <= 1'b0;
            timer_hi_q   <= 1'b0;
            err_q        <= 1'b0;
            hp_q         <= '0;
        end else begin
            udma_q       <= udma_events_i;
            adv_timer_q  <= adv_timer_events_i;
            gpio_q       <= gpio_event_i;
            hwpe_q       <= fc_hwpe_events_i;
            dma_pe_evt_q <= dma_pe_evt_i;
            dma_pe_irq_q <= dma_pe_irq_i;
            pf_q         <= pf_evt_i;
            timer_lo_q   <= timer_lo_event_i;
            timer_hi_q   <= timer_hi_event_i;
            err_q        <= err_event_i;
            hp_q         <= fc_hp_events_i;
        end
    end

    ////////////////////////////////////////
    // Slow clock edge detect
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            slow_meta_q <= 1'b0;
            slow_sync_q <= 1'b0;
            slow_prev_q <= 1'b0;
        end else begin
            slow_meta_q <= slow_clk_i;
            slow_sync_q <= slow_meta_q;
            slow_prev_q <= slow_sync_q;
        end
    end

    // Rising and falling edges both count as one event
    assign evt.ref_edge      = slow_sync_q ^ slow_prev_q;

    assign evt.udma_evt      = udma_q;
    assign evt.adv_timer_evt = adv_timer_q;
    assign evt.gpio_evt      = gpio_q;
    assign evt.hwpe_evt      = hwpe_q;
    assign evt.dma_pe_evt    = dma_pe_evt_q;
    assign evt.dma_pe_irq    = dma_pe_irq_q;
    assign evt.pf_evt        = pf_q;
    assign evt.timer_lo_evt  = timer_lo_q;
    assign evt.timer_hi_evt  = timer_hi_q;
    assign evt.err_evt       = err_q;
    assign evt.hp_evt        = hp_q;

endmodule

`default_nettype wire

//--- design/event_collect_stage.sv
`timescale 1ns/1ps
`default_nettype none

module event_collect_stage import soc_event_pkg::*; (
    input  logic         clk_i,
    input  logic         reset_i,
    evt_bundle_if.dst    evt,
    input  logic         grant_i,
    input  evt_id_t      grant_id_i,
    output per_evt_vec_t pending_o,
    output fc_evt_vec_t  fc_events_o
);

    fc_evt_vec_t  fc_d;
    fc_evt_vec_t  fc_q;
    per_evt_vec_t per_d;
    per_evt_vec_t clr_d;
    per_evt_vec_t pending_q;

    ////////////////////////////////////////
    // Fabric controller layout
    ////////////////////////////////////////

    always_comb begin
        // Reserved and software bits stay zero
        fc_d = '0;

        fc_d[FC_BIT_DMA_EVT]  = evt.dma_pe_evt;
        fc_d[FC_BIT_DMA_IRQ]  = evt.dma_pe_irq;
        fc_d[FC_BIT_TIMER_LO] = evt.timer_lo_evt;
        fc_d[FC_BIT_TIMER_HI] = evt.timer_hi_evt;
        fc_d[FC_BIT_PF]       = evt.pf_evt;
        fc_d[FC_BIT_REF_EDGE] = evt.ref_edge;
        fc_d[FC_BIT_GPIO]     = evt.gpio_evt;
        fc_d[FC_BIT_ERR]      = evt.err_evt;

        fc_d[FC_BIT_ADV_TIMER_BASE +: ADV_TIMER_EVENTS] = evt.adv_timer_evt;
        fc_d[FC_BIT_HP_BASE +: HP_EVENTS]               = evt.hp_evt;
    end

    ////////////////////////////////////////
    // Peripheral event vector
    ////////////////////////////////////////

    always_comb begin
        // Lines 128 to 134 and 142 up are unused
        per_d = '0;

        per_d[UDMA_EVENTS-1:0]                        = evt.udma_evt;
        per_d[EVT_ADV_TIMER_BASE +: ADV_TIMER_EVENTS] = evt.adv_timer_evt;
        per_d[EVT_GPIO]                               = evt.gpio_evt;
        per_d[EVT_HWPE_BASE +: HWPE_EVENTS]           = evt.hwpe_evt;
    end

    // One-hot clear of the line granted this cycle
    always_comb begin
        clr_d = '0;
        if (grant_i && (grant_id_i < PER_EVNT_NUM)) begin
            clr_d[grant_id_i] = 1'b1;
        end
    end

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            fc_q      <= '0;
            pending_q <= '0;
        end else begin
            fc_q      <= fc_d;
            // A new pulse wins over a clear on the same line
            pending_q <= (pending_q & ~clr_d) | per_d;
        end
    end

    assign fc_events_o = fc_q;
    assign pending_o   = pending_q;

endmodule

`default_nettype wire

//--- design/event_encode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module event_encode_stage import soc_event_pkg::*; (
    input  logic         clk_i,
    input  logic         reset_i,
    input  per_evt_vec_t pending_i,
    output logic         grant_o,
    output evt_id_t      grant_id_o,
    output logic         fc_event_valid_o,
    output evt_id_t      fc_event_data_o,
    input  logic         fc_event_ready_i
);

    encode_state_t state_q;
    encode_state_t state_d;
    evt_id_t       data_q;
    evt_id_t       low_id;
    logic          any_pending;

    ////////////////////////////////////////
    // Lowest pending line
    ////////////////////////////////////////

    // Scan downwards so the lowest set index is the last one kept
    always_comb begin
        low_id = '0;
        for (int i = PER_EVNT_NUM - 1; i >= 0; i--) begin
            if (pending_i[i]) begin
                low_id = EVNT_WIDTH'(i);
            end
        end
    end

    assign any_pending = |pending_i;

    // Grant only while idle, so each grant is a single cycle
    assign grant_o    = (state_q == ENC_IDLE) && any_pending;
    assign grant_id_o = low_id;

    ////////////////////////////////////////
    // Handshake FSM
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ENC_IDLE: begin
                if (any_pending) begin
                    state_d = ENC_HOLD;
                end
            end
            ENC_HOLD: begin
                if (fc_event_ready_i) begin
                    state_d = ENC_IDLE;
                end
            end
            default: state_d = ENC_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ENC_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Id stays put for the whole hold phase
    always_ff @(posedge clk_i) begin
        if (grant_o) begin
            data_q <= low_id;
        end
    end

    assign fc_event_valid_o = (state_q == ENC_HOLD);
    assign fc_event_data_o  = data_q;

endmodule

`default_nettype wire

//--- design/soc_event_path.sv
`timescale 1ns/1ps
`default_nettype none

module soc_event_path import soc_event_pkg::*; (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        slow_clk_i,
    input  logic [UDMA_EVENTS-1:0]      udma_events_i,
    input  logic [ADV_TIMER_EVENTS-1:0] adv_timer_events_i,
    input  logic                        gpio_event_i,
    input  logic [HWPE_EVENTS-1:0]      fc_hwpe_events_i,
    input  logic                        dma_pe_evt_i,
    input  logic                        dma_pe_irq_i,
    input  logic                        pf_evt_i,
    input  logic                        timer_lo_event_i,
    input  logic                        timer_hi_event_i,
    input  logic                        err_event_i,
    input  logic [HP_EVENTS-1:0]        fc_hp_events_i,
    output fc_evt_vec_t                 fc_events_o,
    output logic                        fc_event_valid_o,
    output evt_id_t                     fc_event_data_o,
    input  logic                        fc_event_ready_i
);

    per_evt_vec_t pending;
    logic         grant;
    evt_id_t      grant_id;

    evt_bundle_if u_evt ();

    ////////////////////////////////////////
    // Sync, collect, encode
    ////////////////////////////////////////

    event_sync_stage u_sync (
        .clk_i              ( clk_i              ),
        .reset_i            ( reset_i            ),
        .slow_clk_i         ( slow_clk_i         ),
        .udma_events_i      ( udma_events_i      ),
        .adv_timer_events_i ( adv_timer_events_i ),
        .gpio_event_i       ( gpio_event_i       ),
        .fc_hwpe_events_i   ( fc_hwpe_events_i   ),
        .dma_pe_evt_i       ( dma_pe_evt_i       ),
        .dma_pe_irq_i       ( dma_pe_irq_i       ),
        .pf_evt_i           ( pf_evt_i           ),
        .timer_lo_event_i   ( timer_lo_event_i   ),
        .timer_hi_event_i   ( timer_hi_event_i   ),
        .err_event_i        ( err_event_i        ),
        .fc_hp_events_i     ( fc_hp_events_i     ),
        .evt                ( u_evt.src          )
    );

    event_collect_stage u_collect (
        .clk_i       ( clk_i       ),
        .reset_i     ( reset_i     ),
        .evt         ( u_evt.dst   ),
        .grant_i     ( grant       ),
        .grant_id_i  ( grant_id    ),
        .pending_o   ( pending     ),
        .fc_events_o ( fc_events_o )
    );

    // Granted line is cleared back in the collect stage
    event_encode_stage u_encode (
        .clk_i            ( clk_i            ),
        .reset_i          ( reset_i          ),
        .pending_i        ( pending          ),
        .grant_o          ( grant            ),
        .grant_id_o       ( grant_id         ),
        .fc_event_valid_o ( fc_event_valid_o ),
        .fc_event_data_o  ( fc_event_data_o  ),
        .fc_event_ready_i ( fc_event_ready_i )
    );

endmodule

`default_nettype wire

//--- tests/soc_event_props.sv
`timescale 1ns/1ps
`default_nettype none

module soc_event_props import soc_event_pkg::*; (
    input logic    clk_i,
    input logic    reset_i,
    input logic    grant_o,
    input logic    fc_event_valid_o,
    input evt_id_t fc_event_data_o,
    input logic    fc_event_ready_i
);

    // Offered id stays put until taken
    hold_steady: assert property (@(posedge clk_i) disable iff (reset_i)
        fc_event_valid_o && !fc_event_ready_i |=> fc_event_valid_o && $stable(fc_event_data_o))
        else $error("valid or data changed while ready was low");

    reset_idle: assert property (@(posedge clk_i)
        reset_i |=> !fc_event_valid_o)
        else $error("valid is high after reset");

    // One grant per loaded id
    grant_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        grant_o |=> !grant_o)
        else $error("grant lasted more than one cycle");

endmodule

bind event_encode_stage soc_event_props u_props (
    .clk_i            ( clk_i            ),
    .reset_i          ( reset_i          ),
    .grant_o          ( grant_o          ),
    .fc_event_valid_o ( fc_event_valid_o ),
    .fc_event_data_o  ( fc_event_data_o  ),
    .fc_event_ready_i ( fc_event_ready_i )
);

`default_nettype wire

//--- tests/tb_soc_event_path.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_event_path import soc_event_pkg::*; ();

    // Rough length of all tests in cycles, plus margin
    localparam int RUN_CYCLES     = 6 + 64 + 30 + 40 + 40;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + 200;
    localparam fc_evt_vec_t EDGE_MASK = ~(fc_evt_vec_t'(1) << FC_BIT_REF_EDGE);

    logic                        clk_i;
    logic                        reset_i;
    logic                        slow_clk_i;
    logic [UDMA_EVENTS-1:0]      udma_events_i;
    logic [ADV_TIMER_EVENTS-1:0] adv_timer_events_i;
    logic                        gpio_event_i;
    logic [HWPE_EVENTS-1:0]      fc_hwpe_events_i;
    logic                        dma_pe_evt_i;
    logic                        dma_pe_irq_i;
    logic                        pf_evt_i;
    logic                        timer_lo_event_i;
    logic                        timer_hi_event_i;
    logic                        err_event_i;
    logic [HP_EVENTS-1:0]        fc_hp_events_i;
    logic                        fc_event_ready_i;
    fc_evt_vec_t                 fc_events_o;
    logic                        fc_event_valid_o;
    evt_id_t                     fc_event_data_o;

    logic [15:0]  lfsr_q;
    string        test_name;
    fc_evt_vec_t  exp_d1 = '0;
    fc_evt_vec_t  exp_d2 = '0;
    per_evt_vec_t per_d1 = '0;
    per_evt_vec_t model_pend = '0;
    per_evt_vec_t next_pend;
    logic         model_hold = 1'b0;
    evt_id_t      model_id = '0;
    evt_id_t      delivered[$];
    int           edge_count = 0;
    int           cycle_count = 0;

    soc_event_path uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Galois LFSR, one step per bit taken
    function automatic logic next_rand_bit();
        logic out_bit;
        out_bit = lfsr_q[0];
        lfsr_q  = lfsr_q >> 1;
        if (out_bit) begin
            lfsr_q = lfsr_q ^ 16'hB400;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val[i] = next_rand_bit();
        end
        return val;
    endfunction

    // Expected fabric controller word for the current inputs, edge bit left out
    function automatic fc_evt_vec_t expected_fc();
        fc_evt_vec_t v;
        v = '0;
        v[FC_BIT_DMA_EVT]  = dma_pe_evt_i;
        v[FC_BIT_DMA_IRQ]  = dma_pe_irq_i;
        v[FC_BIT_TIMER_LO] = timer_lo_event_i;
        v[FC_BIT_TIMER_HI] = timer_hi_event_i;
        v[FC_BIT_PF]       = pf_evt_i;
        v[FC_BIT_GPIO]     = gpio_event_i;
        v[FC_BIT_ERR]      = err_event_i;
        v[FC_BIT_ADV_TIMER_BASE +: ADV_TIMER_EVENTS] = adv_timer_events_i;
        v[FC_BIT_HP_BASE +: HP_EVENTS]               = fc_hp_events_i;
        return v;
    endfunction

    function automatic per_evt_vec_t expected_per();
        per_evt_vec_t v;
        v = '0;
        v[UDMA_EVENTS-1:0]                        = udma_events_i;
        v[EVT_ADV_TIMER_BASE +: ADV_TIMER_EVENTS] = adv_timer_events_i;
        v[EVT_GPIO]                               = gpio_event_i;
        v[EVT_HWPE_BASE +: HWPE_EVENTS]           = fc_hwpe_events_i;
        return v;
    endfunction

    function automatic evt_id_t lowest_pending(input per_evt_vec_t p);
        int idx;
        idx = 0;
        while (idx < PER_EVNT_NUM - 1 && !p[idx]) begin
            idx++;
        end
        return evt_id_t'(idx);
    endfunction

    task automatic compare_values(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s: expected %0h, actual %0h", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    task automatic clear_inputs();
        udma_events_i      = '0;
        adv_timer_events_i = '0;
        gpio_event_i       = 1'b0;
        fc_hwpe_events_i   = '0;
        dma_pe_evt_i       = 1'b0;
        dma_pe_irq_i       = 1'b0;
        pf_evt_i           = 1'b0;
        timer_lo_event_i   = 1'b0;
        timer_hi_event_i   = 1'b0;
        err_event_i        = 1'b0;
        fc_hp_events_i     = '0;
    endtask

    // Let the pipeline drain until the model has nothing left
    task automatic settle();
        repeat (3) @(negedge clk_i);
        while (model_pend != '0 || model_hold) begin
            @(negedge clk_i);
        end
        repeat (2) @(negedge clk_i);
    endtask

    ////////////////////////////////////////
    // Compare process and pending model
    ////////////////////////////////////////

    always @(posedge clk_i) begin
        if (!reset_i) begin
            compare_values({test_name, " fc_events_o"}, exp_d2, fc_events_o & EDGE_MASK);
            if (fc_events_o[FC_BIT_REF_EDGE]) begin
                edge_count++;
            end
            compare_values({test_name, " valid"}, model_hold, fc_event_valid_o);
            if (model_hold) begin
                compare_values({test_name, " data"}, model_id, fc_event_data_o);
            end
            next_pend = model_pend;
            if (model_hold) begin
                if (fc_event_ready_i) begin
                    delivered.push_back(fc_event_data_o);
                    model_hold = 1'b0;
                end
            end else if (model_pend != '0) begin
                // Grant the lowest line, its flag clears now
                model_id             = lowest_pending(model_pend);
                model_hold           = 1'b1;
                next_pend[model_id]  = 1'b0;
            end
            model_pend = next_pend | per_d1;
            exp_d2     = exp_d1;
            exp_d1     = expected_fc();
            per_d1     = expected_per();
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1, "Timeout");
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        logic [31:0] rnd;
        int          order_ids[$];
        int          bp_ids[$];

        lfsr_q           = 16'd84;
        test_name        = "reset";
        reset_i          = 1'b1;
        slow_clk_i       = 1'b0;
        fc_event_ready_i = 1'b1;
        clear_inputs();
        repeat (5) @(negedge clk_i);
        reset_i = 1'b0;
        @(negedge clk_i);
        compare_values(test_name, 0, fc_events_o);
        compare_values(test_name, 0, fc_event_valid_o);

        test_name = "mapping";
        for (int c = 0; c < 48; c++) begin
            rnd                = rand_bits(13);
            dma_pe_evt_i       = rnd[0];
            dma_pe_irq_i       = rnd[1];
            timer_lo_event_i   = rnd[2];
            timer_hi_event_i   = rnd[3];
            pf_evt_i           = rnd[4];
            err_event_i        = rnd[5];
            gpio_event_i       = rnd[6];
            fc_hp_events_i     = rnd[8:7];
            adv_timer_events_i = rnd[12:9];
            @(negedge clk_i);
        end
        clear_inputs();
        settle();

        // Both edges of the slow clock count, and nothing else raises the edge bit
        test_name = "ref_edges";
        repeat (6) begin
            slow_clk_i = ~slow_clk_i;
            repeat (4) @(negedge clk_i);
        end
        repeat (6) @(negedge clk_i);
        compare_values(test_name, 6, edge_count);

        test_name = "ordering";
        delivered.delete();
        udma_events_i[3]   = 1'b1;
        udma_events_i[77]  = 1'b1;
        udma_events_i[127] = 1'b1;
        adv_timer_events_i = 4'hF;
        gpio_event_i       = 1'b1;
        fc_hwpe_events_i   = 2'b11;
        @(negedge clk_i);
        clear_inputs();
        settle();
        order_ids = '{3, 77, 127, 135, 136, 137, 138, 139, 140, 141};
        compare_values({test_name, " count"}, order_ids.size(), delivered.size());
        foreach (order_ids[i]) begin
            compare_values(test_name, order_ids[i], delivered[i]);
        end

        // Line 5 is granted first, so its second pulse opens a new pending period
        test_name = "backpressure";
        delivered.delete();
        fc_event_ready_i    = 1'b0;
        udma_events_i[5]    = 1'b1;
        udma_events_i[9]    = 1'b1;
        fc_hwpe_events_i[0] = 1'b1;
        @(negedge clk_i);
        clear_inputs();
        repeat (3) @(negedge clk_i);
        udma_events_i[5]  = 1'b1;
        udma_events_i[9]  = 1'b1;
        udma_events_i[20] = 1'b1;
        @(negedge clk_i);
        clear_inputs();
        @(negedge clk_i);
        udma_events_i[9] = 1'b1;
        @(negedge clk_i);
        clear_inputs();
        repeat (4) @(negedge clk_i);
        fc_event_ready_i = 1'b1;
        settle();
        bp_ids = '{5, 5, 9, 20, 140};
        compare_values({test_name, " count"}, bp_ids.size(), delivered.size());
        foreach (bp_ids[i]) begin
            compare_values(test_name, bp_ids[i], delivered[i]);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
design/soc_event_pkg.sv
design/evt_bundle_if.sv
design/event_sync_stage.sv
design/event_collect_stage.sv
design/event_encode_stage.sv
design/soc_event_path.sv
tests/soc_event_props.sv
tests/tb_soc_event_path.sv

//--- Bender.yml
package:
  name: soc_event_path

sources:
  - design/soc_event_pkg.sv
  - design/evt_bundle_if.sv
  - design/event_sync_stage.sv
  - design/event_collect_stage.sv
  - design/event_encode_stage.sv
  - design/soc_event_path.sv
  - target: test
    files:
      - tests/soc_event_props.sv
      - tests/tb_soc_event_path.sv
